// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    localparam int DATA_WIDTH = 32;                 // Bus and register data width
    localparam int SEL_WIDTH  = DATA_WIDTH / 8;     // One select per byte lane

    // Memory operation codes from the decoder
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,                             // No valid size
        OP_LB   = 4'd1,                             // Load byte, signed
        OP_LH   = 4'd2,                             // Load half, signed
        OP_LW   = 4'd3,                             // Load word
        OP_LBU  = 4'd4,                             // Load byte, unsigned
        OP_LHU  = 4'd5,                             // Load half, unsigned
        OP_SB   = 4'd6,                             // Store byte
        OP_SH   = 4'd7,                             // Store half
        OP_SW   = 4'd8                              // Store word
    } mem_op_t;

    // Access sequencer states
    typedef enum logic [1:0] {
        FETCH  = 2'd0,                              // Issue instruction fetch
        F_WAIT = 2'd1,                              // Wait for fetch ack
        DATA   = 2'd2,                              // Decide on data access
        D_WAIT = 2'd3                               // Wait for data ack
    } acc_state_t;

endpackage

// ==== verilog/mem_request_latch.sv ====
module mem_request_latch #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             capture,        // Sample request this edge
    input  logic [ADDR_WIDTH-1:0]            pc,
    input  logic                             mem_read,
    input  logic                             mem_write,
    input  logic                             mem_source,     // 1 picks FPU data for stores
    input  logic [3:0]                       mem_op,
    input  logic [ADDR_WIDTH-1:0]            alu_address,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   fpu_data,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   reg_data,
    output logic [ADDR_WIDTH-1:0]            fetch_addr,
    output logic                             req_read,
    output logic                             req_write,
    output mem_pkg::mem_op_t                 req_op,
    output logic [ADDR_WIDTH-1:0]            req_addr,
    output logic [mem_pkg::DATA_WIDTH-1:0]   req_store_data
);

    // Fetch is issued in the capture cycle, so the live PC goes out then
    assign fetch_addr = pc;

    // Control flags
    always_ff @(posedge clk) begin
        if (!nrst) begin
            req_read  <= 1'b0;
            req_write <= 1'b0;
        end else if (capture) begin
            req_read  <= mem_read;
            req_write <= mem_write;
        end
    end

    // Payload, only meaningful once flags are set
    always_ff @(posedge clk) begin
        if (capture) begin
            req_op   <= mem_pkg::mem_op_t'(mem_op);    // Raw code, unknown values kept
            req_addr <= alu_address;
            if (mem_source) begin
                req_store_data <= fpu_data;         // FPU register
            end else begin
                req_store_data <= reg_data;         // Integer register file
            end
        end
    end

endmodule

// ==== verilog/mem_access_fsm.sv ====
module mem_access_fsm (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             req_read,       // Latched load request
    input  logic                             req_write,      // Latched store request
    input  logic                             done,           // Bus ack for current access
    input  logic [mem_pkg::DATA_WIDTH-1:0]   load_data,      // Extended load value
    output logic                             capture,
    output logic                             start,
    output logic                             is_fetch,
    output logic                             acc_we,
    output logic                             freeze,
    output logic                             instr_valid,
    output logic                             op_done,
    output logic [mem_pkg::DATA_WIDTH-1:0]   data_to_reg,
    output logic                             reg_write_valid
);

    mem_pkg::acc_state_t state;
    mem_pkg::acc_state_t state_n;
    logic                has_data;                  // Instruction needs a data access
    logic                is_load;                   // Data access is a read

    assign has_data = req_read | req_write;
    assign is_load  = req_read & ~req_write;        // Write wins over read

    // State register
    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= mem_pkg::FETCH;
        end else begin
            state <= state_n;
        end
    end

    // Next state
    always_comb begin
        state_n = state;
        case (state)
            mem_pkg::FETCH: begin
                state_n = mem_pkg::F_WAIT;          // Always one cycle
            end
            mem_pkg::F_WAIT: begin
                if (done) begin
                    state_n = mem_pkg::DATA;
                end
            end
            mem_pkg::DATA: begin
                if (has_data) begin
                    state_n = mem_pkg::D_WAIT;
                end else begin
                    state_n = mem_pkg::FETCH;       // Nothing else to do
                end
            end
            mem_pkg::D_WAIT: begin
                if (done) begin
                    state_n = mem_pkg::FETCH;
                end
            end
            default: begin
                state_n = mem_pkg::FETCH;
            end
        endcase
    end

    // Decoded outputs
    assign capture     = (state == mem_pkg::FETCH);
    assign is_fetch    = (state == mem_pkg::FETCH) | (state == mem_pkg::F_WAIT);
    assign start       = capture | ((state == mem_pkg::DATA) & has_data);
    assign acc_we      = (state == mem_pkg::DATA) & req_write;
    assign freeze      = (state != mem_pkg::FETCH);     // Core runs only in FETCH
    assign instr_valid = (state == mem_pkg::DATA);      // Fetched word is held here
    assign op_done     = ((state == mem_pkg::DATA) & ~has_data) |
                         ((state == mem_pkg::D_WAIT) & done);

    // Load result strobe, one cycle after the ack
    always_ff @(posedge clk) begin
        if (!nrst) begin
            reg_write_valid <= 1'b0;
        end else begin
            reg_write_valid <= (state == mem_pkg::D_WAIT) & done & is_load;
        end
    end

    // Load result value
    always_ff @(posedge clk) begin
        if ((state == mem_pkg::D_WAIT) && done && is_load) begin
            data_to_reg <= load_data;
        end
    end

endmodule

// ==== verilog/load_store_align.sv ====
module load_store_align (
    input  mem_pkg::mem_op_t                 req_op,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   req_store_data,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   rdata,          // Word read from the bus
    input  logic                             is_fetch,
    output logic [mem_pkg::DATA_WIDTH-1:0]   store_data,
    output logic [mem_pkg::SEL_WIDTH-1:0]    sel,
    output logic [mem_pkg::DATA_WIDTH-1:0]   load_data
);

    localparam int DW = mem_pkg::DATA_WIDTH;

    logic [mem_pkg::SEL_WIDTH-1:0] op_sel;          // Lanes touched by the data op

    // Store formatting, always lane 0
    always_comb begin
        store_data = '0;
        case (req_op)
            mem_pkg::OP_SB: store_data = {{(DW-8){1'b0}}, req_store_data[7:0]};
            mem_pkg::OP_SH: store_data = {{(DW-16){1'b0}}, req_store_data[15:0]};
            mem_pkg::OP_SW: store_data = req_store_data;
            default:        store_data = '0;        // Not a store
        endcase
    end

    // Byte selects by access size
    always_comb begin
        case (req_op)
            mem_pkg::OP_LB,
            mem_pkg::OP_LBU,
            mem_pkg::OP_SB: op_sel = 4'b0001;
            mem_pkg::OP_LH,
            mem_pkg::OP_LHU,
            mem_pkg::OP_SH: op_sel = 4'b0011;
            mem_pkg::OP_LW,
            mem_pkg::OP_SW: op_sel = 4'b1111;
            default:        op_sel = 4'b0000;       // Invalid size
        endcase
    end

    assign sel = is_fetch ? 4'b1111 : op_sel;       // Instruction is a full word

    // Load extension
    always_comb begin
        case (req_op)
            mem_pkg::OP_LB:  load_data = {{(DW-8){rdata[7]}}, rdata[7:0]};
            mem_pkg::OP_LH:  load_data = {{(DW-16){rdata[15]}}, rdata[15:0]};
            mem_pkg::OP_LW:  load_data = rdata;
            mem_pkg::OP_LBU: load_data = {{(DW-8){1'b0}}, rdata[7:0]};
            mem_pkg::OP_LHU: load_data = {{(DW-16){1'b0}}, rdata[15:0]};
            default:         load_data = '0;        // Store or invalid code
        endcase
    end

endmodule

// ==== verilog/wb_master_port.sv ====
module wb_master_port #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             start,          // Begin one bus cycle
    input  logic                             acc_we,
    input  logic [ADDR_WIDTH-1:0]            addr,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   store_data,
    input  logic [mem_pkg::SEL_WIDTH-1:0]    sel,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   wb_dat_r,
    input  logic                             wb_ack,
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [ADDR_WIDTH-1:0]            wb_adr,
    output logic [mem_pkg::SEL_WIDTH-1:0]    wb_sel,
    output logic [mem_pkg::DATA_WIDTH-1:0]   wb_dat_w,
    output logic                             done,
    output logic [mem_pkg::DATA_WIDTH-1:0]   rdata
);

    logic [mem_pkg::DATA_WIDTH-1:0] rdata_q;        // Last word read

    assign done  = wb_ack & wb_cyc;                 // Ignore stray acks
    assign rdata = done ? wb_dat_r : rdata_q;       // Valid in ack cycle and after

    // Cycle control
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else if (start) begin
            wb_cyc <= 1'b1;                         // cyc and stb rise together
            wb_stb <= 1'b1;
            wb_we  <= acc_we;
        end else if (done) begin
            wb_cyc <= 1'b0;                         // Low in cycle after ack
            wb_stb <= 1'b0;
        end
    end

    // Request payload, held until ack
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= addr;
            wb_sel   <= sel;
            wb_dat_w <= store_data;
        end
    end

    // Read capture
    always_ff @(posedge clk) begin
        if (done) begin
            rdata_q <= wb_dat_r;
        end
    end

endmodule

// ==== verilog/mem_subsystem.sv ====
module mem_subsystem #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic [ADDR_WIDTH-1:0]            pc,
    input  logic                             mem_read,
    input  logic                             mem_write,
    input  logic                             mem_source,
    input  logic [3:0]                       mem_op,
    input  logic [ADDR_WIDTH-1:0]            alu_address,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   fpu_data,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   reg_data,
    output logic [mem_pkg::DATA_WIDTH-1:0]   instr,
    output logic                             instr_valid,
    output logic [mem_pkg::DATA_WIDTH-1:0]   data_to_reg,
    output logic                             reg_write_valid,
    output logic                             op_done,
    output logic                             freeze,
    output logic                             wb_cyc,
    output logic                             wb_stb,
    output logic                             wb_we,
    output logic [ADDR_WIDTH-1:0]            wb_adr,
    output logic [mem_pkg::SEL_WIDTH-1:0]    wb_sel,
    output logic [mem_pkg::DATA_WIDTH-1:0]   wb_dat_w,
    input  logic [mem_pkg::DATA_WIDTH-1:0]   wb_dat_r,
    input  logic                             wb_ack
);

    logic                           capture;
    logic                           start;
    logic                           is_fetch;
    logic                           acc_we;
    logic                           done;
    logic                           req_read;
    logic                           req_write;
    mem_pkg::mem_op_t               req_op;
    logic [ADDR_WIDTH-1:0]          fetch_addr;
    logic [ADDR_WIDTH-1:0]          req_addr;
    logic [ADDR_WIDTH-1:0]          acc_addr;       // Address of the access being issued
    logic [mem_pkg::DATA_WIDTH-1:0] req_store_data;
    logic [mem_pkg::DATA_WIDTH-1:0] store_data;
    logic [mem_pkg::SEL_WIDTH-1:0]  sel;
    logic [mem_pkg::DATA_WIDTH-1:0] rdata;
    logic [mem_pkg::DATA_WIDTH-1:0] load_data;

    assign acc_addr = is_fetch ? fetch_addr : req_addr;
    assign instr    = rdata;                        // Fetched word held through DATA

    mem_request_latch #(.ADDR_WIDTH(ADDR_WIDTH)) mem_request_latch_i (
        .clk(clk), .nrst(nrst), .capture(capture), .pc(pc),
        .mem_read(mem_read), .mem_write(mem_write), .mem_source(mem_source),
        .mem_op(mem_op), .alu_address(alu_address), .fpu_data(fpu_data),
        .reg_data(reg_data), .fetch_addr(fetch_addr), .req_read(req_read),
        .req_write(req_write), .req_op(req_op), .req_addr(req_addr),
        .req_store_data(req_store_data)
    );

    mem_access_fsm mem_access_fsm_i (
        .clk(clk), .nrst(nrst), .req_read(req_read), .req_write(req_write),
        .done(done), .load_data(load_data), .capture(capture), .start(start),
        .is_fetch(is_fetch), .acc_we(acc_we), .freeze(freeze),
        .instr_valid(instr_valid), .op_done(op_done), .data_to_reg(data_to_reg),
        .reg_write_valid(reg_write_valid)
    );

    load_store_align load_store_align_i (
        .req_op(req_op), .req_store_data(req_store_data), .rdata(rdata),
        .is_fetch(is_fetch), .store_data(store_data), .sel(sel), .load_data(load_data)
    );

    wb_master_port #(.ADDR_WIDTH(ADDR_WIDTH)) wb_master_port_i (
        .clk(clk), .nrst(nrst), .start(start), .acc_we(acc_we), .addr(acc_addr),
        .store_data(store_data), .sel(sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .done(done), .rdata(rdata)
    );

endmodule

// ==== verification/mem_subsystem_props.sv ====
module mem_subsystem_props (
    input logic        clk,
    input logic        nrst,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_we,
    input logic        wb_ack,
    input logic [31:0] wb_adr,
    input logic [3:0]  wb_sel,
    input logic        freeze
);
    timeunit 1ns;
    timeprecision 1ps;

    // Strobe only inside a cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!nrst) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // Request held until the slave answers
    req_stable: assert property (@(posedge clk) disable iff (!nrst)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we) && $stable(wb_sel)))
        else $error("Bus request changed before ack");

    ack_with_stb: assert property (@(posedge clk) disable iff (!nrst) wb_ack |-> wb_stb)
        else $error("wb_ack without wb_stb");

    // Core may run for one cycle only
    freeze_pulse: assert property (@(posedge clk) disable iff (!nrst) !freeze |=> freeze)
        else $error("freeze low for two cycles");

endmodule

bind mem_subsystem mem_subsystem_props mem_subsystem_props_i (
    .clk(clk), .nrst(nrst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_ack(wb_ack), .wb_adr(wb_adr), .wb_sel(wb_sel), .freeze(freeze)
);

// ==== verification/mem_subsystem_tb.sv ====
module mem_subsystem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_TXN     = 60;
    localparam int MAX_CYCLE = 1000;                // 60 x 14 cycles plus reset

    logic        clk;
    logic        nrst;
    logic [31:0] pc;
    logic        mem_read;
    logic        mem_write;
    logic        mem_source;
    logic [3:0]  mem_op;
    logic [31:0] alu_address;
    logic [31:0] fpu_data;
    logic [31:0] reg_data;
    logic [31:0] instr;
    logic        instr_valid;
    logic [31:0] data_to_reg;
    logic        reg_write_valid;
    logic        op_done;
    logic        freeze;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    integer      seed = 6;
    int          err_count = 0;
    int          txn_count = 0;
    int          cycle_count = 0;
    int          rst_cycles = 0;
    int          ack_count = 0;
    int          ack_delay = 0;
    logic        ack_busy = 1'b0;
    logic        expect_fetch = 1'b1;
    logic        load_pending = 1'b0;
    logic        instr_due = 1'b0;                  // Fetch acked last cycle
    logic        fetch_cycle = 1'b1;                // Core should run this cycle
    logic [31:0] load_exp;
    logic [35:0] st_exp;
    logic [31:0] mem [256];                         // Wishbone slave memory

    mem_subsystem #(.ADDR_WIDTH(32)) mem_subsystem_i (.*);

    // Register value of a load from a memory word
    function automatic logic [31:0] expected_load(input logic [3:0] op, input logic [31:0] w);
        case (op)
            4'd1: return {{24{w[7]}}, w[7:0]};
            4'd2: return {{16{w[15]}}, w[15:0]};
            4'd3: return w;
            4'd4: return {24'd0, w[7:0]};
            4'd5: return {16'd0, w[15:0]};
            default: return 32'd0;                  // Store code or no size
        endcase
    endfunction

    // Select and bus data of a store, as {sel, data}
    function automatic logic [35:0] expected_store(input logic [3:0] op, input logic [31:0] v);
        logic [3:0]  s;
        logic [31:0] d;
        case (op)
            4'd1, 4'd4, 4'd6: s = 4'b0001;          // Byte size
            4'd2, 4'd5, 4'd7: s = 4'b0011;          // Half size
            4'd3, 4'd8:       s = 4'b1111;
            default:          s = 4'b0000;
        endcase
        case (op)
            4'd6:    d = {24'd0, v[7:0]};
            4'd7:    d = {16'd0, v[15:0]};
            4'd8:    d = v;
            default: d = 32'd0;                     // Only store codes carry data
        endcase
        return {s, d};
    endfunction

    // New random core request
    task automatic new_request();
        logic [7:0] pc_idx;
        logic [7:0] d_idx;
        pc_idx = 8'($unsigned($random(seed)) % 128);
        d_idx  = 8'(128 + $unsigned($random(seed)) % 16);   // Small window for reuse
        pc          <= {22'd0, pc_idx, 2'b00};
        alu_address <= {22'd0, d_idx, 2'b00};
        mem_op      <= 4'($unsigned($random(seed)) % 9);
        mem_read    <= 1'($random(seed));
        mem_write   <= 1'($random(seed));
        mem_source  <= 1'($random(seed));
        fpu_data    <= $random(seed);
        reg_data    <= $random(seed);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Memory fill from the whole address
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = (32'(i) * 32'h9e37_79b9) ^ {4{8'(i)}};
        end
    end

    // Wishbone slave with 1 to 4 cycle ack delay
    always @(posedge clk) begin
        wb_ack <= 1'b0;
        if (!nrst) begin
            ack_busy = 1'b0;
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (!ack_busy) begin
                ack_busy  = 1'b1;
                ack_delay = int'($unsigned($random(seed)) % 4);
            end
            if (ack_delay == 0) begin
                ack_busy = 1'b0;
                wb_ack  <= 1'b1;
                if (wb_we) begin
                    for (int k = 0; k < 4; k++) begin
                        if (wb_sel[k]) mem[wb_adr[9:2]][8*k +: 8] = wb_dat_w[8*k +: 8];
                    end
                end else begin
                    wb_dat_r <= mem[wb_adr[9:2]];
                end
            end else begin
                ack_delay--;
            end
        end
    end

    // Core stimulus
    initial begin
        nrst = 1'b0;
        wb_dat_r = 32'd0;
        wb_ack = 1'b0;
        pc = 32'd0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_source = 1'b0;
        mem_op = 4'd0;
        alu_address = 32'd0;
        fpu_data = 32'd0;
        reg_data = 32'd0;
        new_request();
        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        while (txn_count < N_TXN) begin
            @(posedge clk);
            if (op_done) begin
                txn_count++;
                new_request();                      // Taken by the next FETCH
            end
        end
        repeat (3) @(posedge clk);                  // Let a last load result land
        $display("errors: %0d, transactions: %0d", err_count, txn_count);
        if (err_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLE) begin
            $display("Timeout: only %0d transactions finished, errors: %0d",
                     txn_count, err_count);
            $display("Test failed");
            $finish;
        end
    end

    // Comparing process
    always @(posedge clk) begin
        if (!nrst || rst_cycles < 9) begin
            rst_cycles++;
            if (rst_cycles > 1) begin               // Skip the undriven first cycle
                assert (!wb_cyc && !wb_stb && !instr_valid && !reg_write_valid && !op_done)
                    else begin
                        err_count++;
                        $display("Control outputs active during or just after reset");
                    end
            end
        end
        if (nrst) begin
            assert (freeze == !fetch_cycle)
                else begin
                    err_count++;
                    $display("error %0t freeze: got %b expected %b",
                             $time, freeze, !fetch_cycle);
                end
            // Fetched word shows in the cycle after the fetch ack
            assert (instr_valid == instr_due)
                else begin
                    err_count++;
                    $display("error %0t instr_valid: got %b expected %b",
                             $time, instr_valid, instr_due);
                end
            if (instr_due) begin
                assert (instr == mem[pc[9:2]])
                    else begin
                        err_count++;
                        $display("error %0t instr: got %h expected %h",
                                 $time, instr, mem[pc[9:2]]);
                    end
            end
            assert (reg_write_valid == load_pending)
                else begin
                    err_count++;
                    $display("error %0t reg_write_valid: got %b expected %b",
                             $time, reg_write_valid, load_pending);
                end
            if (load_pending) begin
                assert (data_to_reg == load_exp)
                    else begin
                        err_count++;
                        $display("error %0t data_to_reg: got %h expected %h",
                                 $time, data_to_reg, load_exp);
                    end
            end
            load_pending = 1'b0;
            if (wb_cyc && expect_fetch) begin
                expect_fetch = 1'b0;
                assert (wb_adr == pc && !wb_we && wb_sel == 4'b1111)
                    else begin
                        err_count++;
                        $display("error %0t fetch wb_adr/wb_we/wb_sel: got %h/%b/%b %s %h/0/1111",
                                 $time, wb_adr, wb_we, wb_sel, "expected", pc);
                    end
            end
            if (wb_ack && wb_cyc && ack_count == 1) begin
                assert (wb_adr == alu_address && wb_we == mem_write)
                    else begin
                        err_count++;
                        $display("error %0t data wb_adr/wb_we: got %h/%b expected %h/%b",
                                 $time, wb_adr, wb_we, alu_address, mem_write);
                    end
                if (mem_write) begin                // Write wins over read
                    st_exp = expected_store(mem_op, mem_source ? fpu_data : reg_data);
                    assert ({wb_sel, wb_dat_w} == st_exp)
                        else begin
                            err_count++;
                            $display("error %0t wb_sel/wb_dat_w: got %b/%h expected %b/%h",
                                     $time, wb_sel, wb_dat_w, st_exp[35:32], st_exp[31:0]);
                        end
                end else if (mem_read) begin
                    load_exp     = expected_load(mem_op, mem[alu_address[9:2]]);
                    load_pending = 1'b1;
                end
            end
            if (op_done) begin
                // Ends with the data ack, or with the fetched word when no data
                assert (ack_count == 1 &&
                        ((mem_read || mem_write) ? (wb_ack && wb_cyc) : instr_due))
                    else begin
                        err_count++;
                        $display("Wrong number of bus cycles or late op_done at %0t", $time);
                    end
            end
            instr_due   = wb_ack && wb_cyc && ack_count == 0;
            fetch_cycle = op_done;
            if (op_done) begin
                ack_count    = 0;
                expect_fetch = 1'b1;
            end else if (wb_ack && wb_cyc) begin
                ack_count++;
            end
        end
    end

endmodule

// ==== compile.f ====
verilog/mem_pkg.sv
verilog/mem_request_latch.sv
verilog/mem_access_fsm.sv
verilog/load_store_align.sv
verilog/wb_master_port.sv
verilog/mem_subsystem.sv
verification/mem_subsystem_props.sv
verification/mem_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the memory stage simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f compile.f --top-module mem_subsystem_tb -o sim
out=$(./obj_dir/sim) || true
echo "$out"

# A missing pass line makes grep, and the script, fail
echo "$out" | grep -q "^Test passed$"
